// ==== hdl/eth_header_insert.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_header_insert (
	input logic clock,
	input logic reset,
	input eth_pkg::axis_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output eth_pkg::axis_beat_t out_beat,
	output logic out_valid,
	input logic out_ready,
	input logic header_valid,
	input eth_pkg::eth_header_t header_out,
	output logic header_pop
);

	import eth_pkg::*;

	insert_state_t state;
	logic drain;
	logic accept;
	logic tail_needed;

	logic [HEADER_BITS-1:0] header_bytes;
	logic [HEADER_BITS-1:0] lead_data;
	logic [HEADER_BYTES-1:0] lead_keep;

	logic [HEADER_BITS-1:0] carry_data;
	logic [HEADER_BYTES-1:0] carry_keep;

	assign drain = !out_valid || out_ready;

	assign in_ready = drain &&
		(state == INSERT_BODY || (state == INSERT_HEADER && header_valid));
	assign accept = in_valid && in_ready;
	assign header_pop = accept && (state == INSERT_HEADER);

	// More than two bytes in the last beat spill into a tail beat
	assign tail_needed = in_beat.keep[CARRY_BYTES];

	// Big-endian fields back to wire order
	always_comb begin
		for (int i = 0; i < MAC_BYTES; i++) begin
			header_bytes[8*i +: 8] = header_out.dest_mac[8*(MAC_BYTES-1-i) +: 8];
			header_bytes[8*(MAC_BYTES+i) +: 8] = header_out.src_mac[8*(MAC_BYTES-1-i) +: 8];
		end
		header_bytes[8*(2*MAC_BYTES) +: 8] = header_out.ether_type[15:8];
		header_bytes[8*(2*MAC_BYTES+1) +: 8] = header_out.ether_type[7:0];
	end

	// Low 14 lanes come from the header or from the previous beat
	always_comb begin
		if (state == INSERT_HEADER) begin
			lead_data = header_bytes;
			lead_keep = '1;
		end else begin
			lead_data = carry_data;
			lead_keep = carry_keep;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= INSERT_HEADER;
			out_valid <= 1'b0;
		end else begin
			if (out_ready) begin
				out_valid <= 1'b0;
			end
			case (state)
				INSERT_HEADER, INSERT_BODY: begin
					if (accept) begin
						out_valid <= 1'b1;
						if (in_beat.last) begin
							state <= tail_needed ? INSERT_TAIL : INSERT_HEADER;
						end else begin
							state <= INSERT_BODY;
						end
					end
				end
				INSERT_TAIL: begin
					if (drain) begin
						out_valid <= 1'b1;
						state <= INSERT_HEADER;
					end
				end
				default: state <= INSERT_HEADER;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			carry_data <= in_beat.data[BEAT_BITS-1:CARRY_BITS];
			carry_keep <= in_beat.keep[BEAT_BYTES-1:CARRY_BYTES];
			out_beat <= '{
				data: {in_beat.data[CARRY_BITS-1:0], lead_data},
				keep: {in_beat.keep[CARRY_BYTES-1:0], lead_keep},
				last: in_beat.last && !tail_needed
			};
		end else if (state == INSERT_TAIL && drain) begin
			out_beat <= '{
				data: {{CARRY_BITS{1'b0}}, carry_data},
				keep: {{CARRY_BYTES{1'b0}}, carry_keep},
				last: 1'b1
			};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/eth_header_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_header_queue (
	input logic clock,
	input logic reset,
	input logic header_push,
	input eth_pkg::eth_header_t header_in,
	output logic queue_full,
	input logic header_pop,
	output logic header_valid,
	output eth_pkg::eth_header_t header_out
);

	import eth_pkg::*;

	eth_header_t mem [HEADER_QUEUE_DEPTH];
	logic [QUEUE_PTR_BITS-1:0] wr_ptr;
	logic [QUEUE_PTR_BITS-1:0] rd_ptr;
	logic [QUEUE_PTR_BITS:0] count;
	logic do_push;
	logic do_pop;

	assign queue_full = (count == (QUEUE_PTR_BITS+1)'(HEADER_QUEUE_DEPTH));
	assign header_valid = (count != '0);
	assign header_out = mem[rd_ptr];

	assign do_push = header_push && !queue_full;
	assign do_pop = header_pop && header_valid;

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= header_in;
		end
	end

	// Depth is a power of two so the pointers wrap on their own
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/eth_header_strip.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_header_strip (
	input logic clock,
	input logic reset,
	input eth_pkg::axis_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output eth_pkg::axis_beat_t out_beat,
	output logic out_valid,
	input logic out_ready,
	output logic header_push,
	output eth_pkg::eth_header_t header_in,
	input logic queue_full
);

	import eth_pkg::*;

	strip_state_t state;
	logic started;
	logic drain;
	logic accept;
	logic tail_needed;

	logic [CARRY_BITS-1:0] carry_data;
	logic [CARRY_BYTES-1:0] carry_keep;

	// Output register empty or emptying this cycle
	assign drain = !out_valid || out_ready;

	assign in_ready = started && drain &&
		(state == STRIP_BODY || (state == STRIP_HEADER && !queue_full));
	assign accept = in_valid && in_ready;
	assign header_push = accept && (state == STRIP_HEADER);

	// Lane 14 set means more than a header's worth in the last beat
	assign tail_needed = in_beat.keep[HEADER_BYTES];

	// Wire order to big-endian fields
	always_comb begin
		for (int i = 0; i < MAC_BYTES; i++) begin
			header_in.dest_mac[8*(MAC_BYTES-1-i) +: 8] = in_beat.data[8*i +: 8];
			header_in.src_mac[8*(MAC_BYTES-1-i) +: 8] = in_beat.data[8*(MAC_BYTES+i) +: 8];
		end
		header_in.ether_type = {in_beat.data[8*(2*MAC_BYTES) +: 8],
			in_beat.data[8*(2*MAC_BYTES+1) +: 8]};
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= STRIP_HEADER;
			out_valid <= 1'b0;
			started <= 1'b0;
		end else begin
			started <= 1'b1;
			if (out_ready) begin
				out_valid <= 1'b0;
			end
			case (state)
				STRIP_HEADER: begin
					if (accept) begin
						state <= STRIP_BODY;
					end
				end
				STRIP_BODY: begin
					if (accept) begin
						out_valid <= 1'b1;
						if (in_beat.last) begin
							state <= tail_needed ? STRIP_TAIL : STRIP_HEADER;
						end
					end
				end
				STRIP_TAIL: begin
					if (drain) begin
						out_valid <= 1'b1;
						state <= STRIP_HEADER;
					end
				end
				default: state <= STRIP_HEADER;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		// Top two lanes of every accepted beat lead the next output
		if (accept) begin
			carry_data <= in_beat.data[BEAT_BITS-1 -: CARRY_BITS];
			carry_keep <= in_beat.keep[BEAT_BYTES-1 -: CARRY_BYTES];
		end

		if (accept && state == STRIP_BODY) begin
			out_beat <= '{
				data: {in_beat.data[HEADER_BITS-1:0], carry_data},
				keep: {in_beat.keep[HEADER_BYTES-1:0], carry_keep},
				last: in_beat.last && !tail_needed
			};
		end else if (state == STRIP_TAIL && drain) begin
			out_beat <= '{
				data: {{HEADER_BITS{1'b0}}, carry_data},
				keep: {{HEADER_BYTES{1'b0}}, carry_keep},
				last: 1'b1
			};
		end
	end

endmodule

`default_nettype wire

// ==== hdl/eth_pkg.sv ====
`default_nettype none

package eth_pkg;

	// Stream and header geometry
	localparam int BEAT_BYTES = 16;
	localparam int BEAT_BITS = BEAT_BYTES * 8;
	localparam int HEADER_BYTES = 14;
	localparam int HEADER_BITS = HEADER_BYTES * 8;
	localparam int CARRY_BYTES = BEAT_BYTES - HEADER_BYTES;
	localparam int CARRY_BITS = CARRY_BYTES * 8;
	localparam int MAC_BYTES = 6;

	localparam int HEADER_QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_BITS = $clog2(HEADER_QUEUE_DEPTH);

	// Byte 0 of the beat in data[7:0]
	typedef struct packed {
		logic [BEAT_BITS-1:0] data;
		logic [BEAT_BYTES-1:0] keep;
		logic last;
	} axis_beat_t;

	// First wire byte sits in the top byte of each field
	typedef struct packed {
		logic [MAC_BYTES*8-1:0] dest_mac;
		logic [MAC_BYTES*8-1:0] src_mac;
		logic [15:0] ether_type;
	} eth_header_t;

	typedef enum logic [1:0] {
		STRIP_HEADER,
		STRIP_BODY,
		STRIP_TAIL
	} strip_state_t;

	typedef enum logic [1:0] {
		INSERT_HEADER,
		INSERT_BODY,
		INSERT_TAIL
	} insert_state_t;

endpackage

`default_nettype wire

// ==== hdl/eth_reflector.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_reflector (
	input logic clock,
	input logic reset,
	input eth_pkg::axis_beat_t in_beat,
	input logic in_valid,
	output logic in_ready,
	output eth_pkg::axis_beat_t out_beat,
	output logic out_valid,
	input logic out_ready
);

	import eth_pkg::*;

	// Payload stream between the realigners
	axis_beat_t mid_beat;
	logic mid_valid;
	logic mid_ready;

	logic header_push;
	eth_header_t header_in;
	logic queue_full;
	logic header_valid;
	logic header_pop;
	eth_header_t queued_header;
	eth_header_t reflected_header;

	eth_header_strip strip (
		.clock(clock),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(mid_beat),
		.out_valid(mid_valid),
		.out_ready(mid_ready),
		.header_push(header_push),
		.header_in(header_in),
		.queue_full(queue_full)
	);

	eth_header_queue queue (
		.clock(clock),
		.reset(reset),
		.header_push(header_push),
		.header_in(header_in),
		.queue_full(queue_full),
		.header_pop(header_pop),
		.header_valid(header_valid),
		.header_out(queued_header)
	);

	// Reply goes back to the sender
	assign reflected_header.dest_mac = queued_header.src_mac;
	assign reflected_header.src_mac = queued_header.dest_mac;
	assign reflected_header.ether_type = queued_header.ether_type;

	eth_header_insert insert (
		.clock(clock),
		.reset(reset),
		.in_beat(mid_beat),
		.in_valid(mid_valid),
		.in_ready(mid_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.header_valid(header_valid),
		.header_out(reflected_header),
		.header_pop(header_pop)
	);

endmodule

`default_nettype wire

// ==== verif/eth_reflector_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_reflector_asserts (
	input logic clock,
	input logic reset,
	input eth_pkg::axis_beat_t out_beat,
	input logic out_valid,
	input logic out_ready
);

	int failures = 0;

	// Beat holds until the sink takes it
	stable_under_stall: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
	else begin
		$error("out_beat changed or out_valid dropped during a stall");
		failures++;
	end

	// Keep runs up from lane 0 with no holes
	keep_contiguous: assert property (@(posedge clock) disable iff (reset)
		out_valid |-> ((({1'b0, out_beat.keep} + 17'd1) & {1'b0, out_beat.keep}) == 17'd0))
	else begin
		$error("out_beat.keep is not contiguous from lane 0");
		failures++;
	end

	last_has_keep: assert property (@(posedge clock) disable iff (reset)
		out_valid && out_beat.last |-> out_beat.keep != '0)
	else begin
		$error("out_beat.last came with an empty keep");
		failures++;
	end

	valid_low_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !out_valid)
	else begin
		$error("out_valid was high in the first cycle after reset");
		failures++;
	end

endmodule

`default_nettype wire

// ==== verif/eth_reflector_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_reflector_tb;

	import eth_pkg::*;

	logic clock;
	logic reset;
	axis_beat_t in_beat;
	logic in_valid;
	logic in_ready;
	axis_beat_t out_beat;
	logic out_valid;
	logic out_ready;

	// 0 always ready, 1 random, 2 held low
	int ready_mode;
	logic [15:0] lfsr_state = 16'd28267;

	logic [7:0] expected_bytes [$];
	int expected_lengths [$];
	int remaining;
	int frames_sent;
	int frames_received;
	int stall_cycles;
	int error_count;
	int test_count;
	int failed_tests;
	int errors_before;

	int edge_lengths [5] = '{18, 30, 31, 32, 47};
	int random_lengths [5] = '{40, 57, 33, 96, 18};
	int burst_lengths [6] = '{18, 29, 45, 32, 60, 20};

	eth_reflector uut (
		.clock(clock),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	bind eth_reflector eth_reflector_asserts protocol_checks (
		.clock(clock),
		.reset(reset),
		.out_beat(out_beat),
		.out_valid(out_valid),
		.out_ready(out_ready)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [7:0] random_bits(input int count);
		logic [7:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
			lfsr_state = {lfsr_state[14:0], feedback};
			value = {value[6:0], feedback};
		end
		return value;
	endfunction

	function automatic int total_errors();
		return error_count + uut.protocol_checks.failures;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$finish;
	endtask

	task automatic report_test(input string name, input int start_errors);
		test_count++;
		if (total_errors() == start_errors) begin
			$display("%s: ok", name);
		end else begin
			failed_tests++;
			$display("%s: FAIL, %0d errors", name, total_errors() - start_errors);
		end
	endtask

	task automatic wait_in_ready(input int limit);
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!in_ready) begin
			cycles++;
			if (cycles > limit) begin
				abort_run("Timeout: in_ready did not rise");
			end
			@(negedge clock);
		end
	endtask

	task automatic wait_frames_done(input int limit);
		int cycles;
		cycles = 0;
		while (frames_received != frames_sent) begin
			@(negedge clock);
			cycles++;
			if (cycles > limit) begin
				abort_run("Timeout: not every frame came out of the DUT");
			end
		end
	endtask

	task automatic send_frame(input int length, input logic [7:0] tag);
		logic [7:0] frame [$];
		logic [7:0] value;
		int source;
		for (int i = 0; i < length; i++) begin
			if (i < 5) value = 8'(8'h10 * i);
			else if (i == 5) value = tag;
			else if (i < 11) value = 8'(8'ha0 + i);
			else if (i == 11) value = ~tag;
			else if (i == 12) value = 8'h08;
			else if (i == 13) value = 8'h00;
			else value = random_bits(8);
			frame.push_back(value);
		end
		// Reflected frame has the two MAC addresses swapped
		for (int i = 0; i < length; i++) begin
			source = (i < 6) ? i + 6 : ((i < 12) ? i - 6 : i);
			expected_bytes.push_back(frame[source]);
		end
		expected_lengths.push_back(length);
		frames_sent++;
		for (int base = 0; base < length; base += BEAT_BYTES) begin
			in_beat = '0;
			for (int lane = 0; lane < BEAT_BYTES && base + lane < length; lane++) begin
				in_beat.data[8*lane +: 8] = frame[base+lane];
				in_beat.keep[lane] = 1'b1;
			end
			in_beat.last = (base + BEAT_BYTES >= length);
			in_valid = 1'b1;
			wait_in_ready(200);
			@(posedge clock);
			#1;
		end
		in_valid = 1'b0;
	endtask

	task automatic check_beat();
		logic [BEAT_BITS-1:0] expected_data;
		logic [BEAT_BITS-1:0] lane_mask;
		logic [BEAT_BYTES-1:0] expected_keep;
		logic expected_last;
		int count;
		if (remaining == 0) begin
			assert (expected_lengths.size() != 0) else begin
				$display("Output beat arrived with no frame outstanding");
				error_count++;
				return;
			end
			remaining = expected_lengths.pop_front();
		end
		count = (remaining < BEAT_BYTES) ? remaining : BEAT_BYTES;
		expected_data = '0;
		lane_mask = '0;
		expected_keep = '0;
		for (int i = 0; i < count; i++) begin
			expected_data[8*i +: 8] = expected_bytes.pop_front();
			lane_mask[8*i +: 8] = 8'hff;
			expected_keep[i] = 1'b1;
		end
		expected_last = (remaining <= BEAT_BYTES);
		assert ((out_beat.data & lane_mask) === expected_data) else begin
			$display("Mismatch out_beat.data expected %h actual %h",
				expected_data, out_beat.data & lane_mask);
			error_count++;
		end
		assert (out_beat.keep === expected_keep) else begin
			$display("Mismatch out_beat.keep expected %h actual %h", expected_keep, out_beat.keep);
			error_count++;
		end
		assert (out_beat.last === expected_last) else begin
			$display("Mismatch out_beat.last expected %h actual %h", expected_last, out_beat.last);
			error_count++;
		end
		remaining -= count;
		if (remaining == 0) begin
			frames_received++;
		end
	endtask

	always @(posedge clock) begin
		#1;
		case (ready_mode)
			0: out_ready = 1'b1;
			1: out_ready = 1'(random_bits(1));
			default: out_ready = 1'b0;
		endcase
	end

	// Stripper may still take a header and one body beat after a stall starts
	always @(negedge clock) begin
		if (reset) begin
			stall_cycles = 0;
		end else begin
			if (out_valid && !out_ready) begin
				assert (!(stall_cycles >= 2 && in_valid && in_ready)) else begin
					$display("Input accepted while the output was stalled for %0d cycles",
						stall_cycles + 1);
					error_count++;
				end
				stall_cycles++;
			end else begin
				stall_cycles = 0;
			end
			if (out_valid && out_ready) begin
				check_beat();
			end
		end
	end

	initial begin
		reset = 1'b1;
		in_beat = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		ready_mode = 0;
		remaining = 0;
		frames_sent = 0;
		frames_received = 0;
		error_count = 0;
		test_count = 0;
		failed_tests = 0;
		repeat (3) @(posedge clock);
		#1 reset = 1'b0;

		errors_before = total_errors();
		@(negedge clock);
		assert (!out_valid) else begin
			$display("Mismatch out_valid expected %h actual %h", 1'b0, out_valid);
			error_count++;
		end
		wait_in_ready(10);
		repeat (20) @(posedge clock);
		report_test("idle after reset", errors_before);

		errors_before = total_errors();
		#1 send_frame(64, 8'h01);
		wait_frames_done(200);
		report_test("single 64-byte frame", errors_before);

		errors_before = total_errors();
		@(posedge clock);
		#1;
		foreach (edge_lengths[i]) begin
			send_frame(edge_lengths[i], 8'(8'h10 + i));
		end
		wait_frames_done(200);
		report_test("tail and no-tail lengths", errors_before);

		errors_before = total_errors();
		ready_mode = 1;
		@(posedge clock);
		#1;
		foreach (random_lengths[i]) begin
			send_frame(random_lengths[i], 8'(8'h20 + i));
		end
		wait_frames_done(500);
		ready_mode = 0;
		report_test("random back-pressure", errors_before);

		errors_before = total_errors();
		@(posedge clock);
		#1;
		fork
			begin
				foreach (burst_lengths[i]) begin
					send_frame(burst_lengths[i], 8'(8'h40 + i));
				end
			end
			begin
				ready_mode = 2;
				repeat (60) @(posedge clock);
				ready_mode = 0;
			end
		join
		wait_frames_done(500);
		report_test("six frames behind a stall", errors_before);

		$display("tests %0d, failing tests %0d, errors %0d",
			test_count, failed_tests, total_errors());
		if (failed_tests == 0 && total_errors() == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/eth_pkg.sv
hdl/eth_header_strip.sv
hdl/eth_header_queue.sv
hdl/eth_header_insert.sv
hdl/eth_reflector.sv
verif/eth_reflector_asserts.sv
verif/eth_reflector_tb.sv
